/* common/strm_ep_macros.svh */
// Fixed widths, register map and CHDR packet type codes
// for the stream endpoint
`ifndef STRM_EP_MACROS_SVH
`define STRM_EP_MACROS_SVH

// Bus and field widths
`define STRM_EP_CHDR_W      64
`define STRM_EP_EPID_W      16
`define STRM_EP_CREDIT_W    16
`define STRM_EP_THROTTLE_W  16
`define STRM_EP_CFG_ADDR_W  8

// Configuration register map
`define STRM_EP_REG_EPID_SELF           8'h00
`define STRM_EP_REG_RESET_AND_FLUSH     8'h04
`define STRM_EP_REG_OSTRM_DST_EPID      8'h0C
`define STRM_EP_REG_OSTRM_CAP_PKTS      8'h28
`define STRM_EP_REG_OSTRM_CREDITS       8'h2C
`define STRM_EP_REG_OSTRM_ROUTE_ERR_CNT 8'h34
`define STRM_EP_REG_OSTRM_THROTTLE      8'h3C

// CHDR packet type codes
`define STRM_EP_PKT_MGMT    3'd0
`define STRM_EP_PKT_STRS    3'd1
`define STRM_EP_PKT_STRC    3'd2
`define STRM_EP_PKT_CTRL    3'd4
`define STRM_EP_PKT_DATA    3'd6
`define STRM_EP_PKT_DATA_TS 3'd7

`endif

/* common/strm_ep_pkg.sv */
// Types shared by the stream endpoint blocks
`include "strm_ep_macros.svh"

package strm_ep_pkg;

  typedef enum logic [2:0] {
    MGMT    = `STRM_EP_PKT_MGMT,
    STRS    = `STRM_EP_PKT_STRS,
    STRC    = `STRM_EP_PKT_STRC,
    CTRL    = `STRM_EP_PKT_CTRL,
    DATA    = `STRM_EP_PKT_DATA,
    DATA_TS = `STRM_EP_PKT_DATA_TS
  } pkt_type_e;

  typedef enum logic [1:0] {
    WAIT_CREDIT,
    HEADER,
    PAYLOAD,
    GAP
  } egress_state_e;

  // CHDR header word, most significant field first
  typedef struct packed {
    logic [5:0]                 vc;
    logic                       eob;
    logic                       eov;
    pkt_type_e                  pkt_type;
    logic [4:0]                 num_mdata;
    logic [15:0]                seq_num;
    logic [15:0]                length;
    logic [`STRM_EP_EPID_W-1:0] dst_epid;
  } chdr_hdr_t;

  typedef struct packed {
    logic [`STRM_EP_CHDR_W-1:0] tdata;
    logic                       tlast;
    logic                       tvalid;
  } chdr_beat_t;

  typedef struct packed {
    logic                          wr;
    logic                          rd;
    logic [`STRM_EP_CFG_ADDR_W-1:0] addr;
    logic [31:0]                   data;
  } cfg_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] data;
  } cfg_resp_t;

  typedef struct packed {
    logic [`STRM_EP_EPID_W-1:0]     dst_epid;
    logic [`STRM_EP_THROTTLE_W-1:0] throttle;
    logic                           flush;
  } ostrm_cfg_t;

  typedef struct packed {
    logic                         valid;
    logic [`STRM_EP_CREDIT_W-1:0] count;
  } credit_ret_t;

endpackage

/* hw/strm_ep_regs.sv */
// Stream endpoint configuration registers with single-cycle
// request/response access and the route error counter
`timescale 1ns/1ps
`include "strm_ep_macros.svh"

module strm_ep_regs (
  input  logic                         rfnoc_chdr_clk,
  input  logic                         rfnoc_chdr_rst,
  input  strm_ep_pkg::cfg_req_t        i_cfg_req,
  output strm_ep_pkg::cfg_resp_t       o_cfg_resp,
  input  logic [`STRM_EP_CREDIT_W-1:0] i_credits,
  input  logic                         i_route_err_stb,
  output logic [`STRM_EP_EPID_W-1:0]   o_epid_self,
  output strm_ep_pkg::ostrm_cfg_t      o_ostrm_cfg,
  output strm_ep_pkg::credit_ret_t     o_cap_load
);

  logic [`STRM_EP_EPID_W-1:0]     epid_self;
  logic [`STRM_EP_EPID_W-1:0]     dst_epid;
  logic [`STRM_EP_CREDIT_W-1:0]   cap_pkts;
  logic [`STRM_EP_THROTTLE_W-1:0] throttle;
  logic                           flush_stb;
  logic [31:0]                    route_err_cnt;
  logic [31:0]                    rd_data;
  logic                           resp_ack;
  logic [31:0]                    resp_data;

  // ------------------------------------------------------------
  // Read decode
  // ------------------------------------------------------------
  always_comb begin
    case (i_cfg_req.addr)
      `STRM_EP_REG_EPID_SELF:           rd_data = 32'(epid_self);
      `STRM_EP_REG_OSTRM_DST_EPID:      rd_data = 32'(dst_epid);
      `STRM_EP_REG_OSTRM_CAP_PKTS:      rd_data = 32'(cap_pkts);
      `STRM_EP_REG_OSTRM_CREDITS:       rd_data = 32'(i_credits);
      `STRM_EP_REG_OSTRM_ROUTE_ERR_CNT: rd_data = route_err_cnt;
      `STRM_EP_REG_OSTRM_THROTTLE:      rd_data = 32'(throttle);
      default:                          rd_data = 32'h0;
    endcase
  end

  // ------------------------------------------------------------
  // Register writes and response
  // ------------------------------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      epid_self     <= '0;
      dst_epid      <= '0;
      cap_pkts      <= '0;
      throttle      <= '0;
      flush_stb     <= 1'b0;
      route_err_cnt <= '0;
      resp_ack      <= 1'b0;
      resp_data     <= '0;
    end else begin
      // Every access completes in one cycle
      resp_ack  <= i_cfg_req.wr | i_cfg_req.rd;
      resp_data <= i_cfg_req.rd ? rd_data : 32'h0;
      // Flush is a one-cycle strobe
      flush_stb <= i_cfg_req.wr && (i_cfg_req.addr == `STRM_EP_REG_RESET_AND_FLUSH) &&
                   i_cfg_req.data[0];
      if (i_cfg_req.wr) begin
        case (i_cfg_req.addr)
          `STRM_EP_REG_EPID_SELF:      epid_self <= i_cfg_req.data[`STRM_EP_EPID_W-1:0];
          `STRM_EP_REG_OSTRM_DST_EPID: dst_epid  <= i_cfg_req.data[`STRM_EP_EPID_W-1:0];
          `STRM_EP_REG_OSTRM_CAP_PKTS: cap_pkts  <= i_cfg_req.data[`STRM_EP_CREDIT_W-1:0];
          `STRM_EP_REG_OSTRM_THROTTLE: throttle  <= i_cfg_req.data[`STRM_EP_THROTTLE_W-1:0];
          default: ;
        endcase
      end
      if (i_route_err_stb) begin
        route_err_cnt <= route_err_cnt + 32'd1;
      end
    end
  end

  // Capacity write also reloads the credit counter
  assign o_cap_load.valid = i_cfg_req.wr && (i_cfg_req.addr == `STRM_EP_REG_OSTRM_CAP_PKTS);
  assign o_cap_load.count = i_cfg_req.data[`STRM_EP_CREDIT_W-1:0];

  assign o_ostrm_cfg.dst_epid = dst_epid;
  assign o_ostrm_cfg.throttle = throttle;
  assign o_ostrm_cfg.flush    = flush_stb;

  assign o_epid_self     = epid_self;
  assign o_cfg_resp.ack  = resp_ack;
  assign o_cfg_resp.data = resp_data;

endmodule

/* hw/ingress/ingress_classifier.sv */
// Ingress header classifier: forwards local data packets to the block,
// drops the rest and extracts returned credits from stream status
`timescale 1ns/1ps
`include "strm_ep_macros.svh"

module ingress_classifier (
  input  logic                       rfnoc_chdr_clk,
  input  logic                       rfnoc_chdr_rst,
  input  strm_ep_pkg::chdr_beat_t    i_xbar_in,
  output logic                       o_xbar_in_ready,
  output strm_ep_pkg::chdr_beat_t    o_blk_out,
  input  logic                       i_blk_out_ready,
  input  logic [`STRM_EP_EPID_W-1:0] i_epid_self,
  output strm_ep_pkg::credit_ret_t   o_credit_ret,
  output logic                       o_route_err_stb
);

  typedef enum logic [1:0] {
    DISP_FWD,
    DISP_DROP,
    DISP_ROUTE_ERR,
    DISP_CREDIT
  } disp_e;

  strm_ep_pkg::chdr_hdr_t       hdr;
  disp_e                        disp_hdr;
  disp_e                        disp_q;
  disp_e                        disp_cur;
  logic                         in_hdr;
  logic                         strs_second;
  logic                         xfer;
  logic [`STRM_EP_CHDR_W-1:0]   out_data;
  logic                         out_last;
  logic                         out_valid;
  logic                         cr_valid;
  logic [`STRM_EP_CREDIT_W-1:0] cr_count;

  assign hdr = strm_ep_pkg::chdr_hdr_t'(i_xbar_in.tdata);

  always_comb begin
    case (hdr.pkt_type)
      strm_ep_pkg::DATA, strm_ep_pkg::DATA_TS:
        disp_hdr = (hdr.dst_epid == i_epid_self) ? DISP_FWD : DISP_ROUTE_ERR;
      strm_ep_pkg::STRS:
        disp_hdr = DISP_CREDIT;
      default:
        disp_hdr = DISP_DROP;
    endcase
  end

  // Header beats decide for themselves and later beats follow the header
  assign disp_cur = in_hdr ? disp_hdr : disp_q;

  // Only forwarded beats can stall on the output register
  assign o_xbar_in_ready = (disp_cur != DISP_FWD) || !out_valid || i_blk_out_ready;
  assign xfer            = i_xbar_in.tvalid && o_xbar_in_ready;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      in_hdr          <= 1'b1;
      disp_q          <= DISP_DROP;
      strs_second     <= 1'b0;
      out_valid       <= 1'b0;
      cr_valid        <= 1'b0;
      o_route_err_stb <= 1'b0;
    end else begin
      o_route_err_stb <= xfer && in_hdr && (disp_hdr == DISP_ROUTE_ERR);
      cr_valid        <= xfer && !in_hdr && strs_second;
      if (xfer) begin
        in_hdr      <= i_xbar_in.tlast;
        strs_second <= in_hdr && (disp_hdr == DISP_CREDIT);
        if (in_hdr) begin
          disp_q <= disp_hdr;
        end
      end
      if (xfer && (disp_cur == DISP_FWD)) begin
        out_valid <= 1'b1;
      end else if (i_blk_out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (xfer && (disp_cur == DISP_FWD)) begin
      out_data <= i_xbar_in.tdata;
      out_last <= i_xbar_in.tlast;
    end
    // Credit count sits in the low bits of the second status beat
    if (xfer && !in_hdr && strs_second) begin
      cr_count <= i_xbar_in.tdata[`STRM_EP_CREDIT_W-1:0];
    end
  end

  assign o_blk_out.tdata    = out_data;
  assign o_blk_out.tlast    = out_last;
  assign o_blk_out.tvalid   = out_valid;
  assign o_credit_ret.valid = cr_valid;
  assign o_credit_ret.count = cr_count;

endmodule

/* hw/egress/credit_counter.sv */
// Packet credit counter for the downstream buffer
`timescale 1ns/1ps
`include "strm_ep_macros.svh"

module credit_counter (
  input  logic                         rfnoc_chdr_clk,
  input  logic                         rfnoc_chdr_rst,
  input  strm_ep_pkg::credit_ret_t     i_cap_load,
  input  logic                         i_flush,
  input  strm_ep_pkg::credit_ret_t     i_credit_ret,
  input  logic                         i_credit_take,
  output logic [`STRM_EP_CREDIT_W-1:0] o_credits,
  output logic                         o_credits_avail
);

  logic [`STRM_EP_CREDIT_W-1:0] capacity;
  logic [`STRM_EP_CREDIT_W-1:0] credits;
  logic [`STRM_EP_CREDIT_W:0]   sum;
  logic [`STRM_EP_CREDIT_W:0]   next;

  // Return and take in the same cycle with a floor at zero
  always_comb begin
    sum  = {1'b0, credits} + (i_credit_ret.valid ? {1'b0, i_credit_ret.count} : '0);
    next = (i_credit_take && (sum != '0)) ? sum - 1'b1 : sum;
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      capacity <= '0;
      credits  <= '0;
    end else if (i_cap_load.valid) begin
      capacity <= i_cap_load.count;
      credits  <= i_cap_load.count;
    end else if (i_flush) begin
      credits <= capacity;
    end else begin
      // Saturate at the top of the range
      credits <= next[`STRM_EP_CREDIT_W] ? '1 : next[`STRM_EP_CREDIT_W-1:0];
    end
  end

  assign o_credits       = credits;
  assign o_credits_avail = (credits != '0);

endmodule

/* hw/egress/egress_fsm.sv */
// Egress packet FSM: waits for credits, rewrites the header and
// inserts the programmed idle gap after each packet
`timescale 1ns/1ps
`include "strm_ep_macros.svh"

module egress_fsm (
  input  logic                    rfnoc_chdr_clk,
  input  logic                    rfnoc_chdr_rst,
  input  strm_ep_pkg::chdr_beat_t i_blk_in,
  output logic                    o_blk_in_ready,
  output strm_ep_pkg::chdr_beat_t o_xbar_out,
  input  logic                    i_xbar_out_ready,
  input  strm_ep_pkg::ostrm_cfg_t i_ostrm_cfg,
  input  logic                    i_credits_avail,
  output logic                    o_credit_take
);

  strm_ep_pkg::egress_state_e     state;
  strm_ep_pkg::chdr_hdr_t         hdr;
  logic [15:0]                    seq_num;
  logic [`STRM_EP_THROTTLE_W-1:0] gap_cnt;
  logic                           xfer;
  logic                           pkt_done;

  // Header rewrite
  always_comb begin
    hdr          = strm_ep_pkg::chdr_hdr_t'(i_blk_in.tdata);
    hdr.dst_epid = i_ostrm_cfg.dst_epid;
    hdr.seq_num  = seq_num;
  end

  // ------------------------------------------------------------
  // Output and handshake per state
  // ------------------------------------------------------------
  always_comb begin
    o_xbar_out.tdata  = i_blk_in.tdata;
    o_xbar_out.tlast  = i_blk_in.tlast;
    o_xbar_out.tvalid = 1'b0;
    o_blk_in_ready    = 1'b0;
    case (state)
      strm_ep_pkg::HEADER: begin
        o_xbar_out.tdata  = hdr;
        o_xbar_out.tvalid = i_blk_in.tvalid;
        o_blk_in_ready    = i_xbar_out_ready;
      end
      strm_ep_pkg::PAYLOAD: begin
        o_xbar_out.tvalid = i_blk_in.tvalid;
        o_blk_in_ready    = i_xbar_out_ready;
      end
      default: ;
    endcase
  end

  assign xfer          = o_xbar_out.tvalid && i_xbar_out_ready;
  assign pkt_done      = xfer && i_blk_in.tlast;
  assign o_credit_take = xfer && (state == strm_ep_pkg::HEADER);

  // ------------------------------------------------------------
  // State and counters
  // ------------------------------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      state   <= strm_ep_pkg::WAIT_CREDIT;
      seq_num <= '0;
      gap_cnt <= '0;
    end else begin
      if (i_ostrm_cfg.flush) begin
        seq_num <= '0;
      end else if (o_credit_take) begin
        seq_num <= seq_num + 16'd1;
      end
      case (state)
        strm_ep_pkg::WAIT_CREDIT:
          if (i_credits_avail && i_blk_in.tvalid) state <= strm_ep_pkg::HEADER;
        strm_ep_pkg::HEADER:
          if (xfer) state <= strm_ep_pkg::PAYLOAD;
        strm_ep_pkg::GAP:
          if (gap_cnt == '0) begin
            state <= strm_ep_pkg::WAIT_CREDIT;
          end else begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        default: ;
      endcase
      // The WAIT_CREDIT cycle counts as the last idle cycle of the gap
      if (pkt_done) begin
        if (i_ostrm_cfg.throttle > `STRM_EP_THROTTLE_W'(1)) begin
          state   <= strm_ep_pkg::GAP;
          gap_cnt <= i_ostrm_cfg.throttle - `STRM_EP_THROTTLE_W'(2);
        end else begin
          state <= strm_ep_pkg::WAIT_CREDIT;
        end
      end
    end
  end

endmodule

/* hw/strm_ep_top.sv */
// Single-channel CHDR stream endpoint with register file,
// ingress classifier and credit-gated egress
`timescale 1ns/1ps
`include "strm_ep_macros.svh"

module strm_ep_top (
  input  logic                    rfnoc_chdr_clk,
  input  logic                    rfnoc_chdr_rst,
  // Configuration port
  input  strm_ep_pkg::cfg_req_t   i_cfg_req,
  output strm_ep_pkg::cfg_resp_t  o_cfg_resp,
  // Crossbar side
  input  strm_ep_pkg::chdr_beat_t i_xbar_in,
  output logic                    o_xbar_in_ready,
  output strm_ep_pkg::chdr_beat_t o_xbar_out,
  input  logic                    i_xbar_out_ready,
  // Block side
  input  strm_ep_pkg::chdr_beat_t i_blk_in,
  output logic                    o_blk_in_ready,
  output strm_ep_pkg::chdr_beat_t o_blk_out,
  input  logic                    i_blk_out_ready,
  output logic                    o_route_err_stb
);

  logic [`STRM_EP_EPID_W-1:0]   epid_self;
  logic [`STRM_EP_CREDIT_W-1:0] credits;
  logic                         credits_avail;
  logic                         credit_take;
  strm_ep_pkg::ostrm_cfg_t      ostrm_cfg;
  strm_ep_pkg::credit_ret_t     cap_load;
  strm_ep_pkg::credit_ret_t     credit_ret;

  strm_ep_regs regs_i (
    .rfnoc_chdr_clk  (rfnoc_chdr_clk),
    .rfnoc_chdr_rst  (rfnoc_chdr_rst),
    .i_cfg_req       (i_cfg_req),
    .o_cfg_resp      (o_cfg_resp),
    .i_credits       (credits),
    .i_route_err_stb (o_route_err_stb),
    .o_epid_self     (epid_self),
    .o_ostrm_cfg     (ostrm_cfg),
    .o_cap_load      (cap_load)
  );

  ingress_classifier ingress_i (
    .rfnoc_chdr_clk  (rfnoc_chdr_clk),
    .rfnoc_chdr_rst  (rfnoc_chdr_rst),
    .i_xbar_in       (i_xbar_in),
    .o_xbar_in_ready (o_xbar_in_ready),
    .o_blk_out       (o_blk_out),
    .i_blk_out_ready (i_blk_out_ready),
    .i_epid_self     (epid_self),
    .o_credit_ret    (credit_ret),
    .o_route_err_stb (o_route_err_stb)
  );

  egress_fsm egress_i (
    .rfnoc_chdr_clk   (rfnoc_chdr_clk),
    .rfnoc_chdr_rst   (rfnoc_chdr_rst),
    .i_blk_in         (i_blk_in),
    .o_blk_in_ready   (o_blk_in_ready),
    .o_xbar_out       (o_xbar_out),
    .i_xbar_out_ready (i_xbar_out_ready),
    .i_ostrm_cfg      (ostrm_cfg),
    .i_credits_avail  (credits_avail),
    .o_credit_take    (credit_take)
  );

  credit_counter credit_i (
    .rfnoc_chdr_clk  (rfnoc_chdr_clk),
    .rfnoc_chdr_rst  (rfnoc_chdr_rst),
    .i_cap_load      (cap_load),
    .i_flush         (ostrm_cfg.flush),
    .i_credit_ret    (credit_ret),
    .i_credit_take   (credit_take),
    .o_credits       (credits),
    .o_credits_avail (credits_avail)
  );

endmodule

/* tests/strm_ep_sva.sv */
// Handshake, response timing and credit checks bound into the endpoint top
`timescale 1ns/1ps
`include "strm_ep_macros.svh"

module strm_ep_sva (
  input logic                         rfnoc_chdr_clk,
  input logic                         rfnoc_chdr_rst,
  input strm_ep_pkg::cfg_req_t        i_cfg_req,
  input strm_ep_pkg::cfg_resp_t       o_cfg_resp,
  input strm_ep_pkg::chdr_beat_t      o_xbar_out,
  input logic                         i_xbar_out_ready,
  input strm_ep_pkg::chdr_beat_t      o_blk_out,
  input logic                         i_blk_out_ready,
  input logic [`STRM_EP_CREDIT_W-1:0] credits,
  input logic                         credit_take
);

  // Stalled beats hold their data
  assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    o_xbar_out.tvalid && !i_xbar_out_ready |=> o_xbar_out.tvalid && $stable(o_xbar_out.tdata))
    else $error("egress beat changed while stalled");

  assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    o_blk_out.tvalid && !i_blk_out_ready |=> o_blk_out.tvalid && $stable(o_blk_out.tdata))
    else $error("block output beat changed while stalled");

  // Ack exactly one cycle after each request
  assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    (i_cfg_req.wr || i_cfg_req.rd) |=> o_cfg_resp.ack)
    else $error("missing configuration ack");

  assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    !(i_cfg_req.wr || i_cfg_req.rd) |=> !o_cfg_resp.ack)
    else $error("configuration ack without request");

  assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    credit_take |-> (credits != '0))
    else $error("credit taken with zero credits");

endmodule

bind strm_ep_top strm_ep_sva sva_i (
  .rfnoc_chdr_clk   (rfnoc_chdr_clk),
  .rfnoc_chdr_rst   (rfnoc_chdr_rst),
  .i_cfg_req        (i_cfg_req),
  .o_cfg_resp       (o_cfg_resp),
  .o_xbar_out       (o_xbar_out),
  .i_xbar_out_ready (i_xbar_out_ready),
  .o_blk_out        (o_blk_out),
  .i_blk_out_ready  (i_blk_out_ready),
  .credits          (credits),
  .credit_take      (credit_take)
);

/* tests/strm_ep_tb.sv */
// Vector-driven testbench for the CHDR stream endpoint
// Register, ingress and egress checks with random back-pressure
`timescale 1ns/1ps
`include "strm_ep_macros.svh"

module strm_ep_tb;

  logic                    rfnoc_chdr_clk;
  logic                    rfnoc_chdr_rst;
  strm_ep_pkg::cfg_req_t   i_cfg_req;
  strm_ep_pkg::cfg_resp_t  o_cfg_resp;
  strm_ep_pkg::chdr_beat_t i_xbar_in;
  logic                    o_xbar_in_ready;
  strm_ep_pkg::chdr_beat_t o_xbar_out;
  logic                    i_xbar_out_ready;
  strm_ep_pkg::chdr_beat_t i_blk_in;
  logic                    o_blk_in_ready;
  strm_ep_pkg::chdr_beat_t o_blk_out;
  logic                    i_blk_out_ready;
  logic                    o_route_err_stb;

  logic [7:0]  ops[$];
  logic [31:0] arg_a[$];
  logic [31:0] arg_b[$];
  logic [31:0] arg_c[$];
  logic [31:0] arg_d[$];
  int          cycle = 0;
  int          watchdog_cycles = 0;
  int          tlast_cycle = 0;
  int          last_gap = 0;

  strm_ep_top strm_ep_top_i (.*);

  initial begin
    rfnoc_chdr_clk = 1'b0;
    forever #2 rfnoc_chdr_clk = ~rfnoc_chdr_clk;
  end

  always @(posedge rfnoc_chdr_clk) begin
    cycle <= cycle + 1;
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("ERROR: %s", what);
      $display("test failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  // Inputs back to idle on the falling edge
  task automatic next_drive_slot;
    @(negedge rfnoc_chdr_clk);
    i_cfg_req        = '0;
    i_xbar_in.tvalid = 1'b0;
    i_blk_in.tvalid  = 1'b0;
    i_blk_out_ready  = 1'b1;
    i_xbar_out_ready = 1'b1;
  endtask

  task automatic reg_access(input logic wr, input logic [7:0] addr, input logic [31:0] data);
    next_drive_slot();
    i_cfg_req.wr   = wr;
    i_cfg_req.rd   = !wr;
    i_cfg_req.addr = addr;
    i_cfg_req.data = wr ? data : 32'h0;
    #1;
    check_value("o_cfg_resp.ack", o_cfg_resp.ack, 1'b0);
    next_drive_slot();
    #1;
    check_value("o_cfg_resp.ack", o_cfg_resp.ack, 1'b1);
    if (!wr) begin
      check_value("o_cfg_resp.data", o_cfg_resp.data, data);
    end
  endtask

  // ------------------------------------------------------------
  // Ingress packet whose forwarded beats must match the input
  // ------------------------------------------------------------
  task automatic send_ingress(input logic [2:0] ptype, input logic [15:0] dst, input int beats,
                              input logic fwd, input logic [15:0] credit);
    strm_ep_pkg::chdr_hdr_t hdr;
    logic [63:0]            pkt[$];
    logic [63:0]            exp_q[$];
    int                     sent;
    int                     idle;
    int                     k;
    int                     err_seen;
    int                     err_exp;
    hdr          = '0;
    hdr.pkt_type = strm_ep_pkg::pkt_type_e'(ptype);
    hdr.seq_num  = 16'($urandom);
    hdr.length   = 16'((beats + 1) * 8);
    hdr.dst_epid = dst;
    pkt.push_back(hdr);
    for (k = 0; k < beats; k++) begin
      if (ptype == `STRM_EP_PKT_STRS) pkt.push_back({48'h0, credit});
      else pkt.push_back({$urandom, $urandom});
    end
    if (fwd) exp_q = pkt;
    // Data packets that are not forwarded carry a wrong endpoint ID
    err_exp  = ((ptype == `STRM_EP_PKT_DATA || ptype == `STRM_EP_PKT_DATA_TS) && !fwd) ? 1 : 0;
    err_seen = 0;
    sent = 0;
    idle = 0;
    while (sent < pkt.size() || exp_q.size() > 0 || idle < 4) begin
      next_drive_slot();
      i_blk_out_ready = ($urandom % 4) != 0;
      if (sent < pkt.size()) begin
        i_xbar_in.tdata  = pkt[sent];
        i_xbar_in.tlast  = (sent == pkt.size() - 1);
        i_xbar_in.tvalid = 1'b1;
      end
      #1;
      if (o_route_err_stb) err_seen++;
      if (i_xbar_in.tvalid && o_xbar_in_ready) sent++;
      if (o_blk_out.tvalid && i_blk_out_ready) begin
        check_true(exp_q.size() > 0, "unexpected beat on o_blk_out");
        check_value("o_blk_out.tdata", o_blk_out.tdata, exp_q[0]);
        check_value("o_blk_out.tlast", o_blk_out.tlast, exp_q.size() == 1);
        void'(exp_q.pop_front());
      end
      if (sent == pkt.size() && exp_q.size() == 0) idle++;
    end
    check_value("o_route_err_stb", 64'(err_seen), 64'(err_exp));
  endtask

  // ------------------------------------------------------------
  // Block packet whose header leaves with new dst_epid and seq_num
  // ------------------------------------------------------------
  task automatic send_block(input int beats, input logic [15:0] dst, input logic [15:0] seq,
                            input logic stall);
    strm_ep_pkg::chdr_hdr_t hdr;
    logic [63:0]            pkt[$];
    logic [63:0]            exp_q[$];
    logic [63:0]            word;
    int                     sent;
    int                     k;
    hdr          = strm_ep_pkg::chdr_hdr_t'({$urandom, $urandom});
    hdr.pkt_type = strm_ep_pkg::DATA;
    pkt.push_back(hdr);
    hdr.dst_epid = dst;
    hdr.seq_num  = seq;
    exp_q.push_back(hdr);
    for (k = 0; k < beats; k++) begin
      word = {$urandom, $urandom};
      pkt.push_back(word);
      exp_q.push_back(word);
    end
    sent = 0;
    while (exp_q.size() > 0) begin
      next_drive_slot();
      if (stall) i_xbar_out_ready = ($urandom % 4) != 0;
      i_blk_in.tdata  = pkt[sent];
      i_blk_in.tlast  = (sent == pkt.size() - 1);
      i_blk_in.tvalid = 1'b1;
      #1;
      if (o_xbar_out.tvalid && i_xbar_out_ready) begin
        if (exp_q.size() == pkt.size()) last_gap = cycle - tlast_cycle - 1;
        check_value("o_blk_in_ready", o_blk_in_ready, 1'b1);
        check_value("o_xbar_out.tdata", o_xbar_out.tdata, exp_q[0]);
        check_value("o_xbar_out.tlast", o_xbar_out.tlast, exp_q.size() == 1);
        void'(exp_q.pop_front());
        if (exp_q.size() == 0) tlast_cycle = cycle;
      end
      if (i_blk_in.tvalid && o_blk_in_ready) sent++;
    end
  endtask

  // Header offered without credits must not leave
  task automatic expect_blocked(input int cycles);
    logic [63:0] word;
    word = {$urandom, $urandom};
    repeat (cycles) begin
      next_drive_slot();
      i_blk_in.tdata  = word;
      i_blk_in.tlast  = 1'b0;
      i_blk_in.tvalid = 1'b1;
      #1;
      check_value("o_xbar_out.tvalid", o_xbar_out.tvalid, 1'b0);
      check_value("o_blk_in_ready", o_blk_in_ready, 1'b0);
    end
  endtask

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge rfnoc_chdr_clk);
    $display("ERROR: watchdog expired after %0d cycles", watchdog_cycles);
    $display("test failed");
    $fatal(1, "simulation timed out");
  end

  initial begin
    int          fd;
    int          idx;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    void'($urandom(70));
    rfnoc_chdr_rst   = 1'b1;
    i_cfg_req        = '0;
    i_xbar_in        = '0;
    i_blk_in         = '0;
    i_blk_out_ready  = 1'b1;
    i_xbar_out_ready = 1'b1;
    fd = $fopen("tests/strm_ep_vectors.txt", "r");
    check_true(fd != 0, "cannot open tests/strm_ep_vectors.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;
      a = 0;
      b = 0;
      c = 0;
      d = 0;
      void'($sscanf(line, "%c %h %h %h %h", op, a, b, c, d));
      ops.push_back(op);
      arg_a.push_back(a);
      arg_b.push_back(b);
      arg_c.push_back(c);
      arg_d.push_back(d);
    end
    $fclose(fd);
    watchdog_cycles = ops.size() * 200;
    repeat (5) @(posedge rfnoc_chdr_clk);
    @(negedge rfnoc_chdr_clk);
    rfnoc_chdr_rst = 1'b0;
    for (idx = 0; idx < ops.size(); idx++) begin
      case (ops[idx])
        "W": reg_access(1'b1, arg_a[idx][7:0], arg_b[idx]);
        "R": reg_access(1'b0, arg_a[idx][7:0], arg_b[idx]);
        "I": send_ingress(arg_a[idx][2:0], arg_b[idx][15:0], arg_c[idx], arg_d[idx][0], 16'h0);
        "S": send_ingress(`STRM_EP_PKT_STRS, 16'h0, 1, 1'b0, arg_a[idx][15:0]);
        "B": send_block(arg_a[idx], arg_b[idx][15:0], arg_c[idx][15:0], arg_d[idx][0]);
        "X": expect_blocked(arg_a[idx]);
        "G": check_value("idle cycles before header", 64'(last_gap), 64'(arg_a[idx]));
        default: check_true(1'b0, $sformatf("unknown vector op at vector %0d", idx));
      endcase
    end
    $display("test passed");
    $finish;
  end

endmodule

/* tests/strm_ep_vectors.txt */
# op a b c d (hex): W addr data | R addr expected | I type dst beats fwd | S credits
# B beats dst seq stall | X cycles blocked | G idle cycles before the last header
W 00 1234
W 0C 0ABC
W 28 8
R 00 1234
R 0C 0ABC
R 28 8
R 2C 8
R 10 0
I 6 1234 3 1
I 7 1234 2 1
I 4 1234 2 0
I 6 5555 2 0
I 7 0001 1 0
R 34 2
B 3 0ABC 0 1
B 1 0ABC 1 1
W 28 2
B 2 0ABC 2 1
B 1 0ABC 3 1
R 2C 0
X 14
S 1
R 2C 1
B 2 0ABC 4 1
W 04 1
R 2C 2
W 3C 5
R 3C 5
B 2 0ABC 0 0
B 2 0ABC 1 0
G 5

/* filelist.f */
+incdir+common
common/strm_ep_pkg.sv
hw/strm_ep_regs.sv
hw/ingress/ingress_classifier.sv
hw/egress/credit_counter.sv
hw/egress/egress_fsm.sv
hw/strm_ep_top.sv
tests/strm_ep_sva.sv
tests/strm_ep_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module strm_ep_tb -f filelist.f
	@out="$$(./obj_dir/Vstrm_ep_tb)"; echo "$$out"; echo "$$out" | grep -q "test passed"

clean:
	rm -rf obj_dir
